// File: spike_count_pkg.sv
package spike_count_pkg;

    // defaults picked up by the top level
    parameter int DEFAULT_N_CHANNELS = 4;
    parameter int DEFAULT_CNT_WIDTH  = 16;
    parameter int DEFAULT_WIN_WIDTH  = 24;

    // window sequencer states
    typedef enum logic {
        seq_idle     = 1'b0,
        seq_counting = 1'b1
    } seq_state_t;

    // channel index width, at least one bit even for a single channel
    function automatic int ch_width(input int n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

endpackage

// File: spike_sync.sv
`timescale 1ns/100ps

module spike_sync #(
    parameter int N_CHANNELS = 4
) (
    input  logic                  fast_clk,
    input  logic                  reset,
    input  logic [N_CHANNELS-1:0] spike,
    input  logic                  slow_clk,
    output logic [N_CHANNELS-1:0] spike_event,
    output logic                  slow_rise
);

    // spike lanes plus slow_clk in the top bit
    localparam int N_IN = N_CHANNELS + 1;

    logic [N_IN-1:0] sync_1;
    logic [N_IN-1:0] sync_2;
    logic [N_IN-1:0] prev;
    logic [N_IN-1:0] rise_q;

    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
            prev   <= '0;
            rise_q <= '0;
        end else begin
            // first flop may go metastable, second one settles it
            sync_1 <= {slow_clk, spike};
            sync_2 <= sync_1;
            prev   <= sync_2;
            // registered edge pulse, three cycles after first sample
            rise_q <= sync_2 & ~prev;
        end
    end

    assign spike_event = rise_q[N_CHANNELS-1:0];
    assign slow_rise   = rise_q[N_CHANNELS];

endmodule

// File: window_sequencer.sv
`timescale 1ns/100ps

module window_sequencer #(
    parameter int WIN_WIDTH = 24
) (
    input  logic                 fast_clk,
    input  logic                 reset,
    input  logic                 slow_rise,
    output logic                 window_end,
    output logic [WIN_WIDTH-1:0] window_cycles
);

    import spike_count_pkg::*;

    seq_state_t           state;
    logic [WIN_WIDTH-1:0] cycle_cnt;
    logic [WIN_WIDTH-1:0] cycle_cnt_inc;

    // saturating increment, a stuck slow_clk must not wrap the measurement
    assign cycle_cnt_inc = (&cycle_cnt) ? cycle_cnt : cycle_cnt + 1'b1;

    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            state         <= seq_idle;
            cycle_cnt     <= '0;
            window_end    <= 1'b0;
            window_cycles <= '0;
        end else begin
            window_end <= 1'b0;
            case (state)
                seq_idle: begin
                    // leave idle on the first clock after reset release
                    state <= seq_counting;
                end
                seq_counting: begin
                    if (slow_rise) begin
                        window_end    <= 1'b1;
                        window_cycles <= cycle_cnt_inc;
                        // the window_end cycle is cycle zero of the next window
                        cycle_cnt     <= '0;
                    end else begin
                        cycle_cnt <= cycle_cnt_inc;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

endmodule

// File: spike_counter.sv
`timescale 1ns/100ps

module spike_counter #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                 fast_clk,
    input  logic                 reset,
    input  logic                 spike_event,
    input  logic                 window_end,
    output logic [CNT_WIDTH-1:0] snap_count,
    output logic                 snap_saturated
);

    logic [CNT_WIDTH-1:0] cnt;
    logic                 sat;
    logic [CNT_WIDTH-1:0] cnt_next;
    logic                 sat_next;

    // count including this cycle's event, stops at all ones
    always_comb begin
        cnt_next = cnt;
        if (spike_event && !(&cnt)) begin
            cnt_next = cnt + 1'b1;
        end
        sat_next = sat | (&cnt_next);
    end

    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            cnt            <= '0;
            sat            <= 1'b0;
            snap_count     <= '0;
            snap_saturated <= 1'b0;
        end else if (window_end) begin
            // hand over the total and restart in the same edge,
            // so a coincident event lands in this snapshot only
            snap_count     <= cnt_next;
            snap_saturated <= sat_next;
            cnt            <= '0;
            sat            <= 1'b0;
        end else begin
            cnt <= cnt_next;
            sat <= sat_next;
        end
    end

endmodule

// File: frame_readout.sv
`timescale 1ns/100ps

module frame_readout #(
    parameter int N_CHANNELS = 4,
    parameter int CNT_WIDTH  = 16
) (
    input  logic                                            fast_clk,
    input  logic                                            reset,
    input  logic                                            window_end,
    input  logic [N_CHANNELS*CNT_WIDTH-1:0]                 snap_count,
    input  logic [N_CHANNELS-1:0]                           snap_saturated,
    output logic                                            count_valid,
    output logic [spike_count_pkg::ch_width(N_CHANNELS)-1:0] count_channel,
    output logic [CNT_WIDTH-1:0]                            count_value,
    output logic                                            count_saturated,
    output logic                                            frame_overrun
);

    import spike_count_pkg::*;

    localparam int CH_WIDTH = ch_width(N_CHANNELS);
    localparam logic [CH_WIDTH-1:0] LAST_CH = CH_WIDTH'(N_CHANNELS - 1);

    logic                busy;
    logic [CH_WIDTH-1:0] ch_idx;
    logic                overrun_q;

    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            ch_idx    <= '0;
            overrun_q <= 1'b0;
        end else begin
            overrun_q <= 1'b0;
            if (window_end) begin
                // a new snapshot cuts off any frame still in flight
                overrun_q <= busy;
                busy      <= 1'b1;
                ch_idx    <= '0;
            end else if (busy) begin
                if (ch_idx == LAST_CH) begin
                    busy   <= 1'b0;
                    ch_idx <= '0;
                end else begin
                    ch_idx <= ch_idx + 1'b1;
                end
            end
        end
    end

    assign count_valid   = busy;
    assign count_channel = ch_idx;
    assign frame_overrun = overrun_q;

    // snapshot lanes are registers that only move on window_end,
    // the same edge that restarts the index at channel 0
    assign count_value     = snap_count[ch_idx*CNT_WIDTH +: CNT_WIDTH];
    assign count_saturated = snap_saturated[ch_idx];

endmodule

// File: spike_count_top.sv
`timescale 1ns/100ps

module spike_count_top #(
    parameter int N_CHANNELS = spike_count_pkg::DEFAULT_N_CHANNELS,
    parameter int CNT_WIDTH  = spike_count_pkg::DEFAULT_CNT_WIDTH,
    parameter int WIN_WIDTH  = spike_count_pkg::DEFAULT_WIN_WIDTH
) (
    input  logic                                             fast_clk,
    input  logic                                             reset,
    input  logic [N_CHANNELS-1:0]                            spike,
    input  logic                                             slow_clk,
    output logic                                             window_end,
    output logic [WIN_WIDTH-1:0]                             window_cycles,
    output logic                                             count_valid,
    output logic [spike_count_pkg::ch_width(N_CHANNELS)-1:0] count_channel,
    output logic [CNT_WIDTH-1:0]                             count_value,
    output logic                                             count_saturated,
    output logic                                             frame_overrun
);

    logic [N_CHANNELS-1:0]           spike_event;
    logic                            slow_rise;
    logic [N_CHANNELS*CNT_WIDTH-1:0] snap_count;
    logic [N_CHANNELS-1:0]           snap_saturated;

    spike_sync #(
        .N_CHANNELS (N_CHANNELS)
    ) u_spike_sync (
        .fast_clk    (fast_clk),
        .reset       (reset),
        .spike       (spike),
        .slow_clk    (slow_clk),
        .spike_event (spike_event),
        .slow_rise   (slow_rise)
    );

    window_sequencer #(
        .WIN_WIDTH (WIN_WIDTH)
    ) u_window_sequencer (
        .fast_clk      (fast_clk),
        .reset         (reset),
        .slow_rise     (slow_rise),
        .window_end    (window_end),
        .window_cycles (window_cycles)
    );

    // one counter per spike lane
    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_counter
        spike_counter #(
            .CNT_WIDTH (CNT_WIDTH)
        ) u_spike_counter (
            .fast_clk       (fast_clk),
            .reset          (reset),
            .spike_event    (spike_event[c]),
            .window_end     (window_end),
            .snap_count     (snap_count[c*CNT_WIDTH +: CNT_WIDTH]),
            .snap_saturated (snap_saturated[c])
        );
    end

    frame_readout #(
        .N_CHANNELS (N_CHANNELS),
        .CNT_WIDTH  (CNT_WIDTH)
    ) u_frame_readout (
        .fast_clk        (fast_clk),
        .reset           (reset),
        .window_end      (window_end),
        .snap_count      (snap_count),
        .snap_saturated  (snap_saturated),
        .count_valid     (count_valid),
        .count_channel   (count_channel),
        .count_value     (count_value),
        .count_saturated (count_saturated),
        .frame_overrun   (frame_overrun)
    );

endmodule

// File: tb_spike_count_top.sv
`timescale 1ns/100ps

module tb_spike_count_top;

    import spike_count_pkg::*;

    localparam int N_CH  = DEFAULT_N_CHANNELS;
    localparam int CNT_W = 6;
    localparam int WIN_W = DEFAULT_WIN_WIDTH;
    localparam int CH_W  = ch_width(N_CH);
    localparam int CAP   = (1 << CNT_W) - 1;

    localparam int MODE_OFF    = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_BURST  = 2;

    logic              fast_clk;
    logic              reset;
    logic [N_CH-1:0]   spike;
    logic              slow_clk;
    logic              window_end;
    logic [WIN_W-1:0]  window_cycles;
    logic              count_valid;
    logic [CH_W-1:0]   count_channel;
    logic [CNT_W-1:0]  count_value;
    logic              count_saturated;
    logic              frame_overrun;

    integer seed = 32'ha748fb5f;
    int     errors = 0;
    int     checks = 0;
    int     cyc = 0;

    // stimulus control
    int spike_mode = MODE_OFF;
    int burst_left = 0;
    int slow_random = 1;
    int slow_period = 30;
    int slow_left = 30;
    int slow_lo = 15;
    int sp_left [N_CH];

    // reference model state
    logic [2:0] sp_pipe [N_CH];
    logic [3:0] we_pipe = '0;
    int ref_cnt [N_CH];
    int ref_snap [N_CH];
    bit ref_sat [N_CH];
    int exp_left = 0;
    int exp_ch = 0;
    bit exp_ovr = 0;
    int windows_seen = 0;
    int rise_times [$];
    bit sum_on = 0;
    int driven_total = 0;
    int beat_sum = 0;
    bit sat_seen = 0;
    bit overrun_seen = 0;

    spike_count_top #(
        .N_CHANNELS (N_CH),
        .CNT_WIDTH  (CNT_W),
        .WIN_WIDTH  (WIN_W)
    ) u_spike_count_top (
        .fast_clk        (fast_clk),
        .reset           (reset),
        .spike           (spike),
        .slow_clk        (slow_clk),
        .window_end      (window_end),
        .window_cycles   (window_cycles),
        .count_valid     (count_valid),
        .count_channel   (count_channel),
        .count_value     (count_value),
        .count_saturated (count_saturated),
        .frame_overrun   (frame_overrun)
    );

    always #10 fast_clk = ~fast_clk;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    endtask

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else report_mismatch(name, expected, actual);
    endtask

    task automatic check_outputs();
        compare("window_end timing", int'(we_pipe[3]), int'(window_end));
        compare("frame_overrun", int'(exp_ovr), int'(frame_overrun));
        compare("count_valid", int'(exp_left > 0), int'(count_valid));
        if (count_valid && exp_left > 0) begin
            compare("count_channel", exp_ch, int'(count_channel));
            compare("count_value", ref_snap[exp_ch], int'(count_value));
            compare("count_saturated", int'(ref_sat[exp_ch]), int'(count_saturated));
            if (sum_on) begin
                beat_sum += int'(count_value);
            end
            if (count_saturated) begin
                sat_seen = 1;
            end
        end
        if (frame_overrun) begin
            overrun_seen = 1;
        end
        if (window_end) begin
            windows_seen++;
            if (windows_seen >= 2) begin
                compare("window_cycles", rise_times[windows_seen-1] - rise_times[windows_seen-2],
                        int'(window_cycles));
            end
        end else if (windows_seen == 0) begin
            compare("window_cycles after reset", 0, int'(window_cycles));
        end
    endtask

    task automatic update_model();
        int c;
        if (window_end) begin
            exp_ovr  = (exp_left > 0);
            exp_left = N_CH;
            exp_ch   = 0;
        end else begin
            exp_ovr = 0;
            if (exp_left > 0) begin
                exp_left--;
                exp_ch++;
            end
        end
        // events landing now still belong to the window that ends now
        for (c = 0; c < N_CH; c++) begin
            if (sp_pipe[c][2]) begin
                ref_cnt[c]++;
            end
            if (window_end) begin
                ref_snap[c] = (ref_cnt[c] > CAP) ? CAP : ref_cnt[c];
                ref_sat[c]  = (ref_cnt[c] >= CAP);
                ref_cnt[c]  = 0;
            end
        end
    endtask

    task automatic drive_stimulus();
        int c;
        bit rose;
        bit burst;
        int period;
        burst = (spike_mode == MODE_BURST);
        for (c = 0; c < N_CH; c++) begin
            rose = 0;
            if (!reset) begin
                if (sp_left[c] > 0) begin
                    sp_left[c]--;
                end
                if (sp_left[c] == 0) begin
                    if (spike[c]) begin
                        spike[c]   = 1'b0;
                        sp_left[c] = burst ? 2 : rand_range(2, 9);
                    end else if (spike_mode == MODE_RANDOM ||
                                 (burst && c == 0 && burst_left > 0)) begin
                        spike[c]   = 1'b1;
                        rose       = 1;
                        sp_left[c] = burst ? 2 : rand_range(2, 4);
                        if (burst) begin
                            burst_left--;
                        end
                        if (sum_on) begin
                            driven_total++;
                        end
                    end else begin
                        sp_left[c] = 1;
                    end
                end
            end
            sp_pipe[c] = {sp_pipe[c][1:0], rose};
        end
        rose = 0;
        if (!reset) begin
            if (slow_left > 0) begin
                slow_left--;
            end
            if (slow_left == 0) begin
                if (!slow_clk) begin
                    period    = slow_random ? rand_range(20, 40) : slow_period;
                    slow_clk  = 1'b1;
                    rose      = 1;
                    slow_left = period / 2;
                    slow_lo   = period - period / 2;
                    rise_times.push_back(cyc);
                end else begin
                    slow_clk  = 1'b0;
                    slow_left = slow_lo;
                end
            end
        end
        we_pipe = {we_pipe[2:0], rose};
    endtask

    // one fast_clk cycle with all work on the falling edge
    task automatic tick();
        @(negedge fast_clk);
        cyc++;
        if (!reset) begin
            check_outputs();
            update_model();
        end
        drive_stimulus();
    endtask

    task automatic wait_windows(input int count, input int limit);
        int target;
        int n;
        target = windows_seen + count;
        n = 0;
        while (windows_seen < target) begin
            tick();
            n++;
            if (n > limit) begin
                $display("timeout: window_end did not arrive within %0d cycles", limit);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    endtask

    task automatic wait_frame_done(input int limit);
        int n;
        n = 0;
        while (count_valid || exp_left > 0) begin
            tick();
            n++;
            if (n > limit) begin
                $display("timeout: count_valid stayed high for %0d cycles", limit);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    endtask

    initial begin
        fast_clk = 1'b0;
        reset    = 1'b1;
        spike    = '0;
        slow_clk = 1'b0;
        for (int c = 0; c < N_CH; c++) begin
            sp_left[c]  = 1;
            sp_pipe[c]  = '0;
            ref_cnt[c]  = 0;
            ref_snap[c] = 0;
            ref_sat[c]  = 0;
        end
        repeat (16) tick();
        reset  = 1'b0;
        sum_on = 1;

        // random spikes over long windows followed by a flush
        spike_mode = MODE_RANDOM;
        wait_windows(10, 600);
        spike_mode = MODE_OFF;
        wait_windows(2, 200);
        wait_frame_done(50);
        sum_on = 0;
        compare("spike total over frames", driven_total, beat_sum);

        // burst on channel 0 inside one long window
        spike_mode  = MODE_RANDOM;
        slow_random = 0;
        slow_period = 400;
        wait_windows(1, 200);
        spike_mode  = MODE_BURST;
        burst_left  = 70;
        slow_random = 1;
        wait_windows(1, 1000);
        spike_mode = MODE_RANDOM;
        wait_windows(2, 1000);

        // windows shorter than a frame
        slow_random = 0;
        slow_period = 4;
        wait_windows(8, 200);
        slow_random = 1;
        wait_windows(2, 200);
        wait_frame_done(50);

        compare("saturated frame seen", 1, int'(sat_seen));
        compare("frame overrun seen", 1, int'(overrun_seen));
        $display("checks: %0d, errors: %0d, windows: %0d", checks, errors, windows_seen);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
spike_count_pkg.sv
spike_sync.sv
window_sequencer.sv
spike_counter.sv
frame_readout.sv
spike_count_top.sv
tb_spike_count_top.sv

// File: Bender.yml
package:
  name: spike_count

sources:
  - spike_count_pkg.sv
  - spike_sync.sv
  - window_sequencer.sv
  - spike_counter.sv
  - frame_readout.sv
  - spike_count_top.sv
  - target: simulation
    files:
      - tb_spike_count_top.sv
